// ==== Makefile ====
# Verilator build and run of the scalar unit testbench

VERILATOR ?= verilator
TOP       ?= scalar_fixed_unit_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard source/*.sv source/*.svh verif/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  --Mdir $(OBJ_DIR) -o V$(TOP)

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/scalar_arith_defines.svh ====
/* Word and fraction widths and saturation limits
   for the Q16.16 scalar arithmetic unit */

`ifndef SCALAR_ARITH_DEFINES_SVH
`define SCALAR_ARITH_DEFINES_SVH

///////////////////////////////////////////////////////////////////////
// Word format
///////////////////////////////////////////////////////////////////////

// Full signed word width
`define SCALAR_DATA_SIZE 32

// Fraction bits below the binary point
`define SCALAR_FRAC_SIZE 16

///////////////////////////////////////////////////////////////////////
// Saturation limits
///////////////////////////////////////////////////////////////////////

// Largest positive value, just under 32768.0
`define SCALAR_MAX_POS 32'sh7fff_ffff

// Most negative value, exactly -32768.0
`define SCALAR_MAX_NEG 32'sh8000_0000

`endif

// ==== source/scalar_ctrl_pkg.sv ====
/* Control types of the scalar unit: opcode
   and the state encodings of each block */

package scalar_ctrl_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Opcodes
  ///////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_MUL = 2'b10,
    OP_DIV = 2'b11
  } opcode_t;

  ///////////////////////////////////////////////////////////////////////
  // States
  ///////////////////////////////////////////////////////////////////////

  // Two-step FSM of adder and multiplier
  typedef enum logic {
    STARTER_STATE = 1'b0,
    ENDER_STATE   = 1'b1
  } step_state_t;

  // Divider FSM
  // Literals share the package scope, hence the prefix on the last one
  typedef enum logic [1:0] {
    IDLE_STATE      = 2'b00,
    ITERATE_STATE   = 2'b01,
    DIV_ENDER_STATE = 2'b10
  } divider_state_t;

endpackage

// ==== source/scalar_data_pkg.sv ====
/* Data types of the scalar unit: fixed-point word,
   operand pair and result with overflow flag */

`include "scalar_arith_defines.svh"

package scalar_data_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Fixed-point word
  ///////////////////////////////////////////////////////////////////////

  // Signed Q16.16 value
  typedef logic signed [`SCALAR_DATA_SIZE-1:0] fixed_t;

  ///////////////////////////////////////////////////////////////////////
  // Bundles
  ///////////////////////////////////////////////////////////////////////

  // Operand pair, a sits in the upper half
  typedef struct packed {
    fixed_t a;
    fixed_t b;
  } operands_t;

  // Result word plus overflow flag, 33 bits
  typedef struct packed {
    fixed_t data;
    logic   overflow;
  } result_t;

endpackage

// ==== source/scalar_fixed_adder.sv ====
/* Two-step Q16.16 adder and subtractor
   with signed saturation */

`timescale 1ns/100ps

`include "scalar_arith_defines.svh"

module scalar_fixed_adder (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       START,
  input  logic                       SUBTRACT,
  input  scalar_data_pkg::operands_t OPERANDS,
  output logic                       READY,
  output scalar_data_pkg::result_t   RESULT
);

  // One guard bit above the word
  localparam int SUM_SIZE = `SCALAR_DATA_SIZE + 1;

  ///////////////////////////////////////////////////////////////////////
  // Signals
  ///////////////////////////////////////////////////////////////////////

  scalar_ctrl_pkg::step_state_t adder_fsm;

  // Latched operands and operation
  scalar_data_pkg::fixed_t data_a;
  scalar_data_pkg::fixed_t data_b;
  logic                    subtract_int;

  // Sign-extended operands and raw sum
  logic [SUM_SIZE-1:0] ext_a;
  logic [SUM_SIZE-1:0] ext_b;
  logic [SUM_SIZE-1:0] sum;

  scalar_data_pkg::result_t sum_result;

  ///////////////////////////////////////////////////////////////////////
  // Datapath
  ///////////////////////////////////////////////////////////////////////

  assign ext_a = {data_a[`SCALAR_DATA_SIZE-1], data_a};
  assign ext_b = {data_b[`SCALAR_DATA_SIZE-1], data_b};
  assign sum   = subtract_int ? ext_a - ext_b : ext_a + ext_b;

  // Guard bit differs from word MSB on overflow
  always_comb begin
    if (sum[SUM_SIZE-1] != sum[SUM_SIZE-2]) begin
      sum_result.overflow = 1'b1;
      // Guard bit holds the true sign
      sum_result.data     = sum[SUM_SIZE-1] ? `SCALAR_MAX_NEG : `SCALAR_MAX_POS;
    end else begin
      sum_result.overflow = 1'b0;
      sum_result.data     = sum[`SCALAR_DATA_SIZE-1:0];
    end
  end

  // Operand capture on accepted START
  always_ff @(posedge CLK) begin
    if (adder_fsm == scalar_ctrl_pkg::STARTER_STATE && START) begin
      data_a       <= OPERANDS.a;
      data_b       <= OPERANDS.b;
      subtract_int <= SUBTRACT;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Control
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY     <= 1'b0;
      RESULT    <= '0;
      adder_fsm <= scalar_ctrl_pkg::STARTER_STATE;
    end else begin
      case (adder_fsm)
        scalar_ctrl_pkg::STARTER_STATE: begin
          // Step 0, wait for START
          READY <= 1'b0;
          if (START) begin
            adder_fsm <= scalar_ctrl_pkg::ENDER_STATE;
          end
        end
        scalar_ctrl_pkg::ENDER_STATE: begin
          // Step 1, publish result
          RESULT    <= sum_result;
          READY     <= 1'b1;
          adder_fsm <= scalar_ctrl_pkg::STARTER_STATE;
        end
      endcase
    end
  end

endmodule

// ==== source/scalar_fixed_divider.sv ====
/* Iterative restoring Q16.16 divider, one quotient bit
   per cycle, with saturation and divide-by-zero overflow */

`timescale 1ns/100ps

`include "scalar_arith_defines.svh"

module scalar_fixed_divider (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       START,
  input  scalar_data_pkg::operands_t OPERANDS,
  output logic                       READY,
  output scalar_data_pkg::result_t   RESULT
);

  // Dividend widened by the fraction bits
  localparam int QUOT_SIZE  = `SCALAR_DATA_SIZE + `SCALAR_FRAC_SIZE;
  localparam int COUNT_SIZE = $clog2(QUOT_SIZE);
  localparam int LAST_STEP  = QUOT_SIZE - 1;

  ///////////////////////////////////////////////////////////////////////
  // Signals
  ///////////////////////////////////////////////////////////////////////

  scalar_ctrl_pkg::divider_state_t divider_fsm;
  logic [COUNT_SIZE-1:0]           step_count;

  // MAX_NEG magnitude still fits unsigned
  logic [`SCALAR_DATA_SIZE-1:0] mag_a;
  logic [`SCALAR_DATA_SIZE-1:0] mag_b;
  logic [`SCALAR_DATA_SIZE-1:0] divisor;

  // Sign bookkeeping
  logic negative;
  logic neg_dividend;
  logic div_zero;

  // Remainder stays below the divisor
  logic [`SCALAR_DATA_SIZE-1:0] remainder;
  // Dividend bits shift out the top and quotient bits in the bottom
  logic [QUOT_SIZE-1:0]         quotient;

  logic [`SCALAR_DATA_SIZE:0]   rem_shift;
  logic [`SCALAR_DATA_SIZE:0]   rem_diff;
  logic                         quot_bit;

  logic                         too_large;
  scalar_data_pkg::result_t     quot_result;

  ///////////////////////////////////////////////////////////////////////
  // Datapath
  ///////////////////////////////////////////////////////////////////////

  assign mag_a = OPERANDS.a[`SCALAR_DATA_SIZE-1] ? -OPERANDS.a : OPERANDS.a;
  assign mag_b = OPERANDS.b[`SCALAR_DATA_SIZE-1] ? -OPERANDS.b : OPERANDS.b;

  // One restoring step
  assign rem_shift = {remainder, quotient[QUOT_SIZE-1]};
  assign rem_diff  = rem_shift - {1'b0, divisor};
  assign quot_bit  = (rem_shift >= {1'b0, divisor});

  // Magnitude limit depends on result sign
  assign too_large = negative ?
    (quotient > {{(`SCALAR_FRAC_SIZE){1'b0}}, `SCALAR_MAX_NEG}) :
    (quotient > {{(`SCALAR_FRAC_SIZE){1'b0}}, `SCALAR_MAX_POS});

  always_comb begin
    if (div_zero) begin
      // Saturate toward the dividend sign
      quot_result.overflow = 1'b1;
      quot_result.data     = neg_dividend ? `SCALAR_MAX_NEG : `SCALAR_MAX_POS;
    end else if (too_large) begin
      quot_result.overflow = 1'b1;
      quot_result.data     = negative ? `SCALAR_MAX_NEG : `SCALAR_MAX_POS;
    end else begin
      quot_result.overflow = 1'b0;
      quot_result.data     = negative ? -quotient[`SCALAR_DATA_SIZE-1:0] :
                                         quotient[`SCALAR_DATA_SIZE-1:0];
    end
  end

  // Load on START and shift while iterating
  always_ff @(posedge CLK) begin
    if (divider_fsm == scalar_ctrl_pkg::IDLE_STATE && START) begin
      divisor      <= mag_b;
      negative     <= OPERANDS.a[`SCALAR_DATA_SIZE-1] ^ OPERANDS.b[`SCALAR_DATA_SIZE-1];
      neg_dividend <= OPERANDS.a[`SCALAR_DATA_SIZE-1];
      div_zero     <= (OPERANDS.b == '0);
      remainder    <= '0;
      quotient     <= {mag_a, {(`SCALAR_FRAC_SIZE){1'b0}}};
    end else if (divider_fsm == scalar_ctrl_pkg::ITERATE_STATE) begin
      // Restore by keeping the old remainder
      remainder <= quot_bit ? rem_diff[`SCALAR_DATA_SIZE-1:0] :
                              rem_shift[`SCALAR_DATA_SIZE-1:0];
      quotient  <= {quotient[QUOT_SIZE-2:0], quot_bit};
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Control
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY       <= 1'b0;
      RESULT      <= '0;
      step_count  <= '0;
      divider_fsm <= scalar_ctrl_pkg::IDLE_STATE;
    end else begin
      case (divider_fsm)
        scalar_ctrl_pkg::IDLE_STATE: begin
          READY <= 1'b0;
          if (START) begin
            step_count  <= '0;
            divider_fsm <= scalar_ctrl_pkg::ITERATE_STATE;
          end
        end
        scalar_ctrl_pkg::ITERATE_STATE: begin
          // 48 steps even for a zero divisor
          if (step_count == COUNT_SIZE'(LAST_STEP)) begin
            divider_fsm <= scalar_ctrl_pkg::DIV_ENDER_STATE;
          end else begin
            step_count <= step_count + COUNT_SIZE'(1);
          end
        end
        scalar_ctrl_pkg::DIV_ENDER_STATE: begin
          RESULT      <= quot_result;
          READY       <= 1'b1;
          divider_fsm <= scalar_ctrl_pkg::IDLE_STATE;
        end
        default: begin
          divider_fsm <= scalar_ctrl_pkg::IDLE_STATE;
        end
      endcase
    end
  end

endmodule

// ==== source/scalar_fixed_multiplier.sv ====
/* Two-step Q16.16 multiplier with fraction
   realignment and signed saturation */

`timescale 1ns/100ps

`include "scalar_arith_defines.svh"

module scalar_fixed_multiplier (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       START,
  input  scalar_data_pkg::operands_t OPERANDS,
  output logic                       READY,
  output scalar_data_pkg::result_t   RESULT
);

  // Full product width
  localparam int PRODUCT_SIZE = 2 * `SCALAR_DATA_SIZE;

  ///////////////////////////////////////////////////////////////////////
  // Signals
  ///////////////////////////////////////////////////////////////////////

  scalar_ctrl_pkg::step_state_t multiplier_fsm;

  // Latched operands
  scalar_data_pkg::fixed_t data_a;
  scalar_data_pkg::fixed_t data_b;

  // Q32.32 product and its Q48.16 realignment
  logic signed [PRODUCT_SIZE-1:0] product;
  logic signed [PRODUCT_SIZE-1:0] shifted;

  // Upper bits must all equal the word sign
  logic fits;

  scalar_data_pkg::result_t product_result;

  ///////////////////////////////////////////////////////////////////////
  // Datapath
  ///////////////////////////////////////////////////////////////////////

  // Signed operands sign-extended to 64 bits
  assign product = PRODUCT_SIZE'(data_a) * PRODUCT_SIZE'(data_b);

  // Arithmetic shift floors toward minus infinity
  assign shifted = product >>> `SCALAR_FRAC_SIZE;

  assign fits = (&shifted[PRODUCT_SIZE-1:`SCALAR_DATA_SIZE-1]) ||
                ~(|shifted[PRODUCT_SIZE-1:`SCALAR_DATA_SIZE-1]);

  always_comb begin
    if (fits) begin
      product_result.overflow = 1'b0;
      product_result.data     = shifted[`SCALAR_DATA_SIZE-1:0];
    end else begin
      product_result.overflow = 1'b1;
      product_result.data     = shifted[PRODUCT_SIZE-1] ? `SCALAR_MAX_NEG : `SCALAR_MAX_POS;
    end
  end

  // Operand capture
  always_ff @(posedge CLK) begin
    if (multiplier_fsm == scalar_ctrl_pkg::STARTER_STATE && START) begin
      data_a <= OPERANDS.a;
      data_b <= OPERANDS.b;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Control
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY          <= 1'b0;
      RESULT         <= '0;
      multiplier_fsm <= scalar_ctrl_pkg::STARTER_STATE;
    end else begin
      case (multiplier_fsm)
        scalar_ctrl_pkg::STARTER_STATE: begin
          // Step 0
          READY <= 1'b0;
          if (START) begin
            multiplier_fsm <= scalar_ctrl_pkg::ENDER_STATE;
          end
        end
        scalar_ctrl_pkg::ENDER_STATE: begin
          // Step 1 publishes the product
          RESULT         <= product_result;
          READY          <= 1'b1;
          multiplier_fsm <= scalar_ctrl_pkg::STARTER_STATE;
        end
      endcase
    end
  end

endmodule

// ==== source/scalar_fixed_unit.sv ====
/* Scalar unit top: opcode dispatch of START and
   result selection from adder, multiplier, divider */

`timescale 1ns/100ps

module scalar_fixed_unit (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       START,
  input  scalar_ctrl_pkg::opcode_t   OPCODE,
  input  scalar_data_pkg::operands_t OPERANDS,
  output logic                       READY,
  output scalar_data_pkg::result_t   RESULT
);

  ///////////////////////////////////////////////////////////////////////
  // Signals
  ///////////////////////////////////////////////////////////////////////

  // Per-block strobes
  logic start_add;
  logic start_mul;
  logic start_div;
  logic subtract;

  logic ready_add;
  logic ready_mul;
  logic ready_div;

  scalar_data_pkg::result_t result_add;
  scalar_data_pkg::result_t result_mul;
  scalar_data_pkg::result_t result_div;

  // Block that finished last, OP_ADD also covers subtract
  scalar_ctrl_pkg::opcode_t last_op;
  scalar_ctrl_pkg::opcode_t result_sel;

  ///////////////////////////////////////////////////////////////////////
  // Dispatch
  ///////////////////////////////////////////////////////////////////////

  assign subtract  = (OPCODE == scalar_ctrl_pkg::OP_SUB);
  assign start_add = START && (OPCODE == scalar_ctrl_pkg::OP_ADD || subtract);
  assign start_mul = START && (OPCODE == scalar_ctrl_pkg::OP_MUL);
  assign start_div = START && (OPCODE == scalar_ctrl_pkg::OP_DIV);

  scalar_fixed_adder i_adder (
    .CLK      (CLK),
    .RST      (RST),
    .START    (start_add),
    .SUBTRACT (subtract),
    .OPERANDS (OPERANDS),
    .READY    (ready_add),
    .RESULT   (result_add)
  );

  scalar_fixed_multiplier i_multiplier (
    .CLK      (CLK),
    .RST      (RST),
    .START    (start_mul),
    .OPERANDS (OPERANDS),
    .READY    (ready_mul),
    .RESULT   (result_mul)
  );

  scalar_fixed_divider i_divider (
    .CLK      (CLK),
    .RST      (RST),
    .START    (start_div),
    .OPERANDS (OPERANDS),
    .READY    (ready_div),
    .RESULT   (result_div)
  );

  ///////////////////////////////////////////////////////////////////////
  // Completion
  ///////////////////////////////////////////////////////////////////////

  // Only one block runs, so at most one READY
  assign READY = ready_add | ready_mul | ready_div;

  // Finishing block wins, else keep the last one
  always_comb begin
    result_sel = last_op;
    if (ready_add) begin
      result_sel = scalar_ctrl_pkg::OP_ADD;
    end else if (ready_mul) begin
      result_sel = scalar_ctrl_pkg::OP_MUL;
    end else if (ready_div) begin
      result_sel = scalar_ctrl_pkg::OP_DIV;
    end
  end

  always_comb begin
    case (result_sel)
      scalar_ctrl_pkg::OP_MUL: RESULT = result_mul;
      scalar_ctrl_pkg::OP_DIV: RESULT = result_div;
      default:                 RESULT = result_add;
    endcase
  end

  // Holds RESULT steady between operations
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      last_op <= scalar_ctrl_pkg::OP_ADD;
    end else begin
      last_op <= result_sel;
    end
  end

endmodule

// ==== verif/scalar_fixed_unit_tb.sv ====
/* Testbench of the scalar unit: vector table, LCG random vectors,
   reference model, compare tasks and cycle watchdog */

`timescale 1ns/100ps

`include "scalar_arith_defines.svh"

module scalar_fixed_unit_tb;

  localparam int NUM_RANDOM = 40;
  // Per-operation cycle budget
  // Divider operation takes about 53 of them
  localparam int WAIT_LIMIT = 60;

  // Short opcode names for the table
  localparam scalar_ctrl_pkg::opcode_t ADD = scalar_ctrl_pkg::OP_ADD;
  localparam scalar_ctrl_pkg::opcode_t SUB = scalar_ctrl_pkg::OP_SUB;
  localparam scalar_ctrl_pkg::opcode_t MUL = scalar_ctrl_pkg::OP_MUL;
  localparam scalar_ctrl_pkg::opcode_t DIV = scalar_ctrl_pkg::OP_DIV;

  typedef struct packed {
    scalar_ctrl_pkg::opcode_t op;
    scalar_data_pkg::fixed_t  a;
    scalar_data_pkg::fixed_t  b;
    scalar_data_pkg::result_t expected;
  } vector_t;

  ///////////////////////////////////////////////////////////////////////
  // Signals and bookkeeping
  ///////////////////////////////////////////////////////////////////////

  logic                       CLK;
  logic                       RST;
  logic                       start;
  scalar_ctrl_pkg::opcode_t   opcode;
  scalar_data_pkg::operands_t operands;
  logic                       ready;
  scalar_data_pkg::result_t   result;

  // Value RESULT must hold until the next READY
  scalar_data_pkg::result_t   last_result;

  vector_t     table_vec[$];
  logic [31:0] lcg_state = 32'hf980;
  int          vec_index;
  int          check_count;
  int          error_count;
  int          cycle_count;
  int          cycle_limit;

  scalar_fixed_unit i_dut (
    .CLK      (CLK),
    .RST      (RST),
    .START    (start),
    .OPCODE   (opcode),
    .OPERANDS (operands),
    .READY    (ready),
    .RESULT   (result)
  );

  // 100 ns clock
  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  ///////////////////////////////////////////////////////////////////////
  // Helpers
  ///////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Expected result from the Q16.16 rules in 64-bit integers
  function automatic scalar_data_pkg::result_t model_result(
    input scalar_ctrl_pkg::opcode_t op,
    input scalar_data_pkg::fixed_t  op_a,
    input scalar_data_pkg::fixed_t  op_b
  );
    longint                   wide;
    longint                   scale;
    scalar_data_pkg::result_t res;
    scale = 64'sd1 <<< `SCALAR_FRAC_SIZE;
    // Zero divisor saturates toward the dividend sign
    if (op == DIV && op_b == 0) begin
      res.overflow = 1'b1;
      res.data     = (op_a < 0) ? `SCALAR_MAX_NEG : `SCALAR_MAX_POS;
      return res;
    end
    case (op)
      ADD:     wide = longint'(op_a) + longint'(op_b);
      SUB:     wide = longint'(op_a) - longint'(op_b);
      // Floor of the scaled product
      MUL:     wide = (longint'(op_a) * longint'(op_b)) >>> `SCALAR_FRAC_SIZE;
      // Integer divide truncates toward zero
      default: wide = (longint'(op_a) * scale) / longint'(op_b);
    endcase
    if (wide > longint'(`SCALAR_MAX_POS)) begin
      res.overflow = 1'b1;
      res.data     = `SCALAR_MAX_POS;
    end else if (wide < longint'(`SCALAR_MAX_NEG)) begin
      res.overflow = 1'b1;
      res.data     = `SCALAR_MAX_NEG;
    end else begin
      res.overflow = 1'b0;
      res.data     = wide[`SCALAR_DATA_SIZE-1:0];
    end
    return res;
  endfunction

  task automatic compare_data(input string name, input scalar_data_pkg::fixed_t got,
                              input scalar_data_pkg::fixed_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s (vector %0d): got %h, expected %h", name, vec_index, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s (vector %0d): got %h, expected %h", name, vec_index, got, exp);
    end
  endtask

  task automatic push_vector(input scalar_ctrl_pkg::opcode_t op,
                             input scalar_data_pkg::fixed_t op_a,
                             input scalar_data_pkg::fixed_t op_b,
                             input scalar_data_pkg::fixed_t data, input logic ovf);
    vector_t vec;
    vec.op       = op;
    vec.a        = op_a;
    vec.b        = op_b;
    vec.expected = {data, ovf};
    table_vec.push_back(vec);
  endtask

  // One START pulse, wait for READY, check result and its hold
  task automatic run_op(input scalar_ctrl_pkg::opcode_t op,
                        input scalar_data_pkg::fixed_t op_a,
                        input scalar_data_pkg::fixed_t op_b,
                        input scalar_data_pkg::result_t expected);
    int waited;
    @(posedge CLK);
    start    <= 1'b1;
    opcode   <= op;
    operands <= {op_a, op_b};
    @(posedge CLK);
    start  <= 1'b0;
    waited = 0;
    // Previous result stays while the block works
    while (!ready && waited < WAIT_LIMIT) begin
      compare_data("RESULT.data", result.data, last_result.data);
      compare_flag("RESULT.overflow", result.overflow, last_result.overflow);
      @(posedge CLK);
      waited++;
    end
    if (!ready) begin
      error_count++;
      $display("READY never came for vector %0d (%s) within %0d cycles",
               vec_index, op.name(), WAIT_LIMIT);
      return;
    end
    compare_data("RESULT.data", result.data, expected.data);
    compare_flag("RESULT.overflow", result.overflow, expected.overflow);
    last_result = result;
    // READY drops after one cycle and RESULT stays
    @(posedge CLK);
    compare_flag("READY", ready, 1'b0);
    compare_data("RESULT.data", result.data, last_result.data);
    compare_flag("RESULT.overflow", result.overflow, last_result.overflow);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Directed vectors
  ///////////////////////////////////////////////////////////////////////

  task automatic fill_table();
    // Exact sums then saturation both ways
    push_vector(ADD, 32'h0001_8000, 32'h0002_4000, 32'h0003_c000, 1'b0);
    push_vector(ADD, 32'hffff_0000, 32'h0000_8000, 32'hffff_8000, 1'b0);
    push_vector(ADD, 32'h7fff_0000, 32'h0002_0000, 32'h7fff_ffff, 1'b1);
    push_vector(SUB, 32'h0005_0000, 32'h0007_4000, 32'hfffd_c000, 1'b0);
    push_vector(SUB, 32'h8000_0000, 32'h0000_0001, 32'h8000_0000, 1'b1);
    push_vector(SUB, 32'h7fff_ffff, 32'hffff_ffff, 32'h7fff_ffff, 1'b1);
    // Products with floor on the lost bits
    push_vector(MUL, 32'h0001_8000, 32'h0002_0000, 32'h0003_0000, 1'b0);
    push_vector(MUL, 32'hfffe_8000, 32'h0002_8000, 32'hfffc_4000, 1'b0);
    push_vector(MUL, 32'hffff_ffff, 32'h0000_8000, 32'hffff_ffff, 1'b0);
    push_vector(MUL, 32'h0000_0001, 32'h0000_8000, 32'h0000_0000, 1'b0);
    push_vector(MUL, 32'h0100_0000, 32'h0100_0000, 32'h7fff_ffff, 1'b1);
    push_vector(MUL, 32'h0100_0000, 32'hff00_0000, 32'h8000_0000, 1'b1);
    // Quotients for all sign combinations
    push_vector(DIV, 32'h0007_0000, 32'h0002_0000, 32'h0003_8000, 1'b0);
    push_vector(DIV, 32'h0001_0000, 32'h0003_0000, 32'h0000_5555, 1'b0);
    push_vector(DIV, 32'hffff_0000, 32'h0003_0000, 32'hffff_aaab, 1'b0);
    push_vector(DIV, 32'h0001_0000, 32'hfffd_0000, 32'hffff_aaab, 1'b0);
    push_vector(DIV, 32'hffff_0000, 32'hfffd_0000, 32'h0000_5555, 1'b0);
    // Zero divisor
    push_vector(DIV, 32'h0003_0000, 32'h0000_0000, 32'h7fff_ffff, 1'b1);
    push_vector(DIV, 32'hfffd_0000, 32'h0000_0000, 32'h8000_0000, 1'b1);
    push_vector(DIV, 32'h0000_0000, 32'h0000_0000, 32'h7fff_ffff, 1'b1);
    // Quotient range edges
    push_vector(DIV, 32'h0100_0000, 32'h0000_0100, 32'h7fff_ffff, 1'b1);
    push_vector(DIV, 32'h8000_0000, 32'h0001_0000, 32'h8000_0000, 1'b0);
    push_vector(DIV, 32'h8000_0000, 32'hffff_0000, 32'h7fff_ffff, 1'b1);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Sequence
  ///////////////////////////////////////////////////////////////////////

  initial begin
    scalar_ctrl_pkg::opcode_t op;
    scalar_data_pkg::fixed_t  op_a;
    scalar_data_pkg::fixed_t  op_b;
    logic [31:0]              rand_word;
    RST         <= 1'b1;
    start       <= 1'b0;
    opcode      <= ADD;
    operands    <= '0;
    check_count = 0;
    error_count = 0;
    vec_index   = -1;
    last_result = '0;
    fill_table();
    cycle_limit = WAIT_LIMIT * (table_vec.size() + NUM_RANDOM);
    repeat (4) @(posedge CLK);
    RST <= 1'b0;
    // Idle outputs after reset
    @(posedge CLK);
    compare_flag("READY", ready, 1'b0);
    compare_data("RESULT.data", result.data, '0);
    compare_flag("RESULT.overflow", result.overflow, 1'b0);
    foreach (table_vec[i]) begin
      vec_index = i;
      run_op(table_vec[i].op, table_vec[i].a, table_vec[i].b, table_vec[i].expected);
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      vec_index = table_vec.size() + i;
      rand_word = next_rand();
      op        = scalar_ctrl_pkg::opcode_t'(rand_word[31:30]);
      op_a      = next_rand();
      op_b      = next_rand();
      // Random shrink mixes overflow and exact cases
      op_a = op_a >>> rand_word[23:20];
      op_b = op_b >>> rand_word[27:24];
      run_op(op, op_a, op_b, model_result(op, op_a, op_b));
    end
    $display("Checks: %0d  Errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog over the whole run
  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Run stopped after %0d cycles, READY stuck at vector %0d",
               cycle_count, vec_index);
      $display("Checks: %0d  Errors: %0d", check_count, error_count + 1);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    cycle_count = 0;
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/scalar_data_pkg.sv
source/scalar_ctrl_pkg.sv
source/scalar_fixed_adder.sv
source/scalar_fixed_multiplier.sv
source/scalar_fixed_divider.sv
source/scalar_fixed_unit.sv
verif/scalar_fixed_unit_tb.sv
